// ==== hw/chroni_regs_pkg.sv ====
package chroni_regs_pkg;

   localparam logic [8:0] REG_BASE_HI = 9'h120;   // cpu_addr[15:7] of the window at 0x9000

   localparam logic [6:0] REG_DL_LO     = 7'h00;
   localparam logic [6:0] REG_DL_HI     = 7'h01;
   localparam logic [6:0] REG_CHARSET   = 7'h02;
   localparam logic [6:0] REG_PAL_INDEX = 7'h04;
   localparam logic [6:0] REG_PAL_DATA  = 7'h05;
   localparam logic [6:0] REG_VADDR_LO  = 7'h06;
   localparam logic [6:0] REG_VADDR_HI  = 7'h07;
   localparam logic [6:0] REG_VADDR_TOP = 7'h08;   // bit 16 of the byte address
   localparam logic [6:0] REG_VDATA     = 7'h09;
   localparam logic [6:0] REG_BORDER_LO = 7'h1a;
   localparam logic [6:0] REG_BORDER_HI = 7'h1b;

   localparam int COLOR_W      = 16;
   localparam int VRAM_AW      = 16;   // word address
   localparam int VRAM_BYTE_AW = 17;
   localparam int PAL_AW       = 4;

   // palette load sequence: index, low byte, high byte
   localparam logic [1:0] PAL_IDLE = 2'd0;
   localparam logic [1:0] PAL_LO   = 2'd1;
   localparam logic [1:0] PAL_HI   = 2'd2;

endpackage

// ==== hw/chroni_dl_pkg.sv ====
package chroni_dl_pkg;

   // a display list word is an instruction or, after a text instruction, an origin
   typedef union packed {
      struct packed {
         logic [2:0] rsvd;
         logic       narrow;   // 32 columns instead of 40
         logic [3:0] mode;
         logic [7:0] lines;
      } instr;
      logic [15:0] addr;
   } dl_word_u;

   localparam logic [3:0] DL_MODE_BLANK = 4'h0;
   localparam logic [3:0] DL_MODE_TEXT  = 4'h2;
   localparam logic [3:0] DL_MODE_END   = 4'hf;

   localparam int LINE_PIXELS = 320;
   localparam int COLS_WIDE   = 40;
   localparam int COLS_NARROW = 32;
   localparam int CHAR_PIXELS = 8;
   localparam int CHAR_ROWS   = 8;

   localparam int PIXEL_CREDITS = 4;

   // text fetch states
   localparam logic [2:0] FT_IDLE = 3'd0;
   localparam logic [2:0] FT_CHAR = 3'd1;
   localparam logic [2:0] FT_ATTR = 3'd2;
   localparam logic [2:0] FT_FONT = 3'd3;
   localparam logic [2:0] FT_DATA = 3'd4;

endpackage

// ==== hw/chroni_ifs.sv ====
`timescale 1ns/1ps

interface vram_wr_if import chroni_regs_pkg::*; ();
   logic               wr_en;
   logic [VRAM_AW-1:0] addr;
   logic [1:0]         byte_en;   // exactly one lane per write
   logic [15:0]        wr_data;   // byte copied to both lanes

   modport cpu (output wr_en, output addr, output byte_en, output wr_data);
   modport mem (input wr_en, input addr, input byte_en, input wr_data);
endinterface

interface line_cmd_if import chroni_regs_pkg::*; ();
   logic               start;
   logic               blank;
   logic               narrow;
   logic [VRAM_AW-1:0] char_addr;   // word addresses
   logic [VRAM_AW-1:0] attr_addr;
   logic [2:0]         row;
   logic               done;        // with the last pixel

   modport ctrl (
      output start, blank, narrow, char_addr, attr_addr, row,
      input  done
   );
   modport render (
      input  start, blank, narrow, char_addr, attr_addr, row,
      output done
   );
endinterface

// ==== hw/cpu_regs.sv ====
`timescale 1ns/1ps

module cpu_regs
   import chroni_regs_pkg::*;
(
   input  logic               sys_clk,
   input  logic               reset_n,
   input  logic [15:0]        cpu_addr,
   input  logic [7:0]         cpu_wr_data,
   input  logic               cpu_wr_en,
   output logic [7:0]         cpu_rd_data,
   output logic [VRAM_AW-1:0] dl_base,
   output logic [7:0]         charset_base,
   output logic [COLOR_W-1:0] border_color,
   output logic               pal_wr_en,
   output logic [PAL_AW-1:0]  pal_wr_addr,
   output logic [COLOR_W-1:0] pal_wr_data,
   vram_wr_if.cpu             vram_wr
);
   logic                    reg_cs;
   logic [6:0]              reg_off;
   logic [VRAM_BYTE_AW-1:0] vaddr;
   logic [PAL_AW-1:0]       pal_index;
   logic [7:0]              pal_lo;
   logic [1:0]              pal_state;

   assign reg_cs  = cpu_addr[15:7] == REG_BASE_HI;
   assign reg_off = cpu_addr[6:0];

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         dl_base       <= '0;
         charset_base  <= '0;
         border_color  <= '0;
         vaddr         <= '0;
         pal_index     <= '0;
         pal_state     <= PAL_IDLE;
         pal_wr_en     <= 1'b0;
         vram_wr.wr_en <= 1'b0;
      end else begin
         pal_wr_en     <= 1'b0;
         vram_wr.wr_en <= 1'b0;
         if (reg_cs && cpu_wr_en) begin
            case (reg_off)
               REG_DL_LO:     dl_base[7:0] <= cpu_wr_data;
               REG_DL_HI:     dl_base[15:8] <= cpu_wr_data;
               REG_CHARSET:   charset_base <= cpu_wr_data;
               REG_VADDR_LO:  vaddr[7:0] <= cpu_wr_data;
               REG_VADDR_HI:  vaddr[15:8] <= cpu_wr_data;
               REG_VADDR_TOP: vaddr[16] <= cpu_wr_data[0];
               REG_BORDER_LO: border_color[7:0] <= cpu_wr_data;
               REG_BORDER_HI: border_color[15:8] <= cpu_wr_data;
               REG_PAL_INDEX: begin
                  pal_index <= cpu_wr_data[PAL_AW-1:0];
                  pal_state <= PAL_LO;
               end
               REG_PAL_DATA: begin
                  if (pal_state == PAL_LO) begin
                     pal_lo    <= cpu_wr_data;
                     pal_state <= PAL_HI;
                  end else if (pal_state == PAL_HI) begin
                     pal_wr_en   <= 1'b1;
                     pal_wr_addr <= pal_index;
                     pal_wr_data <= {cpu_wr_data, pal_lo};
                     pal_index   <= pal_index + 1'b1;   // next pair fills the next entry
                     pal_state   <= PAL_LO;
                  end
               end
               REG_VDATA: begin
                  vram_wr.wr_en   <= 1'b1;
                  vram_wr.addr    <= vaddr[VRAM_BYTE_AW-1:1];
                  vram_wr.byte_en <= vaddr[0] ? 2'b10 : 2'b01;   // odd byte is the high lane
                  vram_wr.wr_data <= {cpu_wr_data, cpu_wr_data};
                  vaddr           <= vaddr + 1'b1;
               end
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (reg_cs) begin
         case (reg_off)
            REG_DL_LO:     cpu_rd_data <= dl_base[7:0];
            REG_DL_HI:     cpu_rd_data <= dl_base[15:8];
            REG_CHARSET:   cpu_rd_data <= charset_base;
            REG_PAL_INDEX: cpu_rd_data <= {4'd0, pal_index};
            REG_VADDR_LO:  cpu_rd_data <= vaddr[7:0];
            REG_VADDR_HI:  cpu_rd_data <= vaddr[15:8];
            REG_VADDR_TOP: cpu_rd_data <= {7'd0, vaddr[16]};
            REG_BORDER_LO: cpu_rd_data <= border_color[7:0];
            REG_BORDER_HI: cpu_rd_data <= border_color[15:8];
            default:       cpu_rd_data <= 8'h00;
         endcase
      end
   end

endmodule

// ==== hw/vram.sv ====
`timescale 1ns/1ps

module vram
   import chroni_regs_pkg::*;
(
   input  logic               sys_clk,
   input  logic [VRAM_AW-1:0] dl_addr,
   input  logic               dl_rd,
   input  logic [VRAM_AW-1:0] txt_addr,
   output logic [15:0]        rd_data,
   vram_wr_if.mem             vram_wr
);
   logic [15:0]        mem [0:(1<<VRAM_AW)-1];
   logic [VRAM_AW-1:0] rd_addr;

   // display list fetches happen between lines only
   assign rd_addr = dl_rd ? dl_addr : txt_addr;

   always_ff @(posedge sys_clk) begin
      if (vram_wr.wr_en) begin
         if (vram_wr.byte_en[0])
            mem[vram_wr.addr][7:0] <= vram_wr.wr_data[7:0];
         if (vram_wr.byte_en[1])
            mem[vram_wr.addr][15:8] <= vram_wr.wr_data[15:8];
      end
   end

   always_ff @(posedge sys_clk) begin
      rd_data <= mem[rd_addr];
   end

   a_one_lane: assert property (@(posedge sys_clk)
      vram_wr.wr_en |-> $onehot(vram_wr.byte_en))
      else $error("VRAM write without exactly one byte lane");

endmodule

// ==== hw/dl_processor.sv ====
`timescale 1ns/1ps

module dl_processor
   import chroni_regs_pkg::*;
   import chroni_dl_pkg::*;
(
   input  logic               sys_clk,
   input  logic               reset_n,
   input  logic [VRAM_AW-1:0] dl_base,
   input  logic               frame_start,
   input  logic               line_start,
   input  logic [15:0]        rd_data,
   output logic [VRAM_AW-1:0] dl_addr,
   output logic               dl_rd,
   line_cmd_if.ctrl           cmd
);
   dl_word_u           word;
   logic [VRAM_AW-1:0] ptr;
   logic [VRAM_AW-1:0] row_step;
   logic [3:0]         mode;
   logic [7:0]         lines_left;
   logic [1:0]         widx;    // 0 instruction, 1 char origin, 2 attr origin
   logic               phase;   // read data on its way
   logic               busy;

   assign word     = rd_data;
   assign dl_addr  = ptr;
   // one text row is cols bytes, half as many words
   assign row_step = cmd.narrow ? VRAM_AW'(COLS_NARROW / 2) : VRAM_AW'(COLS_WIDE / 2);

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         ptr        <= '0;
         mode       <= DL_MODE_BLANK;
         lines_left <= '0;
         widx       <= '0;
         phase      <= 1'b0;
         busy       <= 1'b0;
         dl_rd      <= 1'b0;
         cmd.start  <= 1'b0;
         cmd.blank  <= 1'b1;
         cmd.narrow <= 1'b0;
         cmd.row    <= '0;
      end else begin
         cmd.start <= 1'b0;
         if (cmd.done)
            busy <= 1'b0;
         if (frame_start) begin
            ptr        <= dl_base;
            mode       <= DL_MODE_BLANK;
            lines_left <= '0;
            dl_rd      <= 1'b0;
         end else if (line_start) begin
            busy <= 1'b1;
            if (mode == DL_MODE_END || lines_left != 8'd0) begin
               lines_left <= lines_left - 8'd1;
               cmd.start  <= 1'b1;
               cmd.blank  <= mode != DL_MODE_TEXT;
               if (mode == DL_MODE_TEXT) begin
                  cmd.row <= cmd.row + 3'd1;   // wraps after the last font row
                  if (cmd.row == 3'(CHAR_ROWS - 1)) begin
                     cmd.char_addr <= cmd.char_addr + row_step;
                     cmd.attr_addr <= cmd.attr_addr + row_step;
                  end
               end
            end else begin
               dl_rd <= 1'b1;
               widx  <= '0;
               phase <= 1'b0;
            end
         end else if (dl_rd) begin
            phase <= !phase;
            if (!phase) begin
               ptr <= ptr + 1'b1;
            end else begin
               widx <= widx + 2'd1;
               case (widx)
                  2'd0: begin
                     mode       <= word.instr.mode;
                     lines_left <= word.instr.lines - 8'd1;
                     cmd.narrow <= word.instr.narrow;
                     cmd.row    <= '0;
                     if (word.instr.mode != DL_MODE_TEXT) begin   // blank, end or unknown
                        dl_rd     <= 1'b0;
                        cmd.start <= 1'b1;
                        cmd.blank <= 1'b1;
                     end
                  end
                  2'd1: cmd.char_addr <= word.addr;
                  default: begin
                     cmd.attr_addr <= word.addr;
                     cmd.blank     <= 1'b0;
                     cmd.start     <= 1'b1;
                     dl_rd         <= 1'b0;
                  end
               endcase
            end
         end
      end
   end

   a_no_overlap: assert property (@(posedge sys_clk) disable iff (!reset_n)
      line_start |-> !busy)
      else $error("line_start while a line is still in progress");

endmodule

// ==== hw/text_renderer.sv ====
`timescale 1ns/1ps

module text_renderer
   import chroni_regs_pkg::*;
   import chroni_dl_pkg::*;
(
   input  logic               sys_clk,
   input  logic               reset_n,
   input  logic [7:0]         charset_base,
   input  logic [COLOR_W-1:0] border_color,
   input  logic               pal_wr_en,
   input  logic [PAL_AW-1:0]  pal_wr_addr,
   input  logic [COLOR_W-1:0] pal_wr_data,
   input  logic [15:0]        rd_data,
   input  logic               pixel_credit,
   output logic [VRAM_AW-1:0] txt_addr,
   output logic               pixel_valid,
   output logic               pixel_last,
   output logic [COLOR_W-1:0] pixel_color,
   line_cmd_if.render         cmd
);
   logic [COLOR_W-1:0]      palette [0:(1<<PAL_AW)-1];
   logic [2:0]              fstate;
   logic [VRAM_BYTE_AW-1:0] rd_byte;   // byte address being fetched
   logic                    sel;
   logic [7:0]              rd_b;
   logic [5:0]              col;
   logic [5:0]              cols;
   logic [7:0]              nxt_bits;
   logic [7:0]              nxt_attr;
   logic                    nxt_full;
   logic [7:0]              sh_bits;
   logic [7:0]              sh_attr;
   logic [3:0]              sh_cnt;
   logic [8:0]              pix_left;
   logic [2:0]              credits;
   logic                    fire;
   logic                    load;

   assign txt_addr = rd_byte[VRAM_BYTE_AW-1:1];
   assign rd_b     = sel ? rd_data[15:8] : rd_data[7:0];
   assign cols     = cmd.narrow ? 6'(COLS_NARROW) : 6'(COLS_WIDE);
   assign fire     = pix_left != 9'd0 && credits != 3'd0 && (cmd.blank || sh_cnt != 4'd0);
   assign load     = nxt_full && (sh_cnt == 4'd0 || (sh_cnt == 4'd1 && fire));

   // per column: char byte, attr byte, then font byte
   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         fstate   <= FT_IDLE;
         col      <= '0;
         nxt_full <= 1'b0;
      end else begin
         if (load)
            nxt_full <= 1'b0;
         if (cmd.start) begin
            col     <= '0;
            rd_byte <= {cmd.char_addr, 1'b0};
            fstate  <= cmd.blank ? FT_IDLE : FT_CHAR;
         end else begin
            case (fstate)
               FT_CHAR:
                  if (!nxt_full) begin   // stall while a font byte is still waiting
                     rd_byte <= {cmd.attr_addr, 1'b0} + col;
                     fstate  <= FT_ATTR;
                  end
               FT_ATTR: begin
                  rd_byte <= {7'(charset_base[6:0] + rd_b[7]), rd_b[6:0], cmd.row};
                  fstate  <= FT_FONT;
               end
               FT_FONT:
                  fstate <= FT_DATA;
               FT_DATA: begin
                  nxt_full <= 1'b1;
                  if (col == cols - 6'd1) begin
                     fstate <= FT_IDLE;
                  end else begin
                     col     <= col + 6'd1;
                     rd_byte <= {cmd.char_addr, 1'b0} + col + 6'd1;
                     fstate  <= FT_CHAR;
                  end
               end
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      sel <= rd_byte[0];   // lane of the word arriving next cycle
      if (pal_wr_en)
         palette[pal_wr_addr] <= pal_wr_data;
      if (fstate == FT_FONT)
         nxt_attr <= rd_b;
      if (fstate == FT_DATA)
         nxt_bits <= rd_b;
      if (load) begin
         sh_bits <= nxt_bits;
         sh_attr <= nxt_attr;
      end else if (fire) begin
         sh_bits <= sh_bits << 1;
      end
      // font bit 1 picks the low attr nibble
      if (fire)
         pixel_color <= cmd.blank ? border_color
                                  : palette[sh_bits[7] ? sh_attr[3:0] : sh_attr[7:4]];
   end

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         pix_left    <= '0;
         sh_cnt      <= '0;
         credits     <= 3'(PIXEL_CREDITS);
         pixel_valid <= 1'b0;
         pixel_last  <= 1'b0;
         cmd.done    <= 1'b0;
      end else begin
         pixel_valid <= fire;
         pixel_last  <= fire && pix_left == 9'd1;
         cmd.done    <= fire && pix_left == 9'd1;
         credits     <= credits - 3'(fire) + 3'(pixel_credit);
         if (cmd.start)
            pix_left <= cmd.blank ? 9'(LINE_PIXELS) : 9'(cols * CHAR_PIXELS);
         else if (fire)
            pix_left <= pix_left - 9'd1;
         if (load)
            sh_cnt <= 4'(CHAR_PIXELS);
         else if (fire && !cmd.blank)
            sh_cnt <= sh_cnt - 4'd1;
      end
   end

   a_credit_max: assert property (@(posedge sys_clk) disable iff (!reset_n)
      credits <= 3'(PIXEL_CREDITS))
      else $error("more credits returned than pixels sent");

endmodule

// ==== hw/chroni_top.sv ====
`timescale 1ns/1ps

module chroni_top
   import chroni_regs_pkg::*;
(
   input  logic               sys_clk,
   input  logic               reset_n,
   input  logic [15:0]        cpu_addr,
   input  logic [7:0]         cpu_wr_data,
   input  logic               cpu_wr_en,
   output logic [7:0]         cpu_rd_data,
   input  logic               frame_start,
   input  logic               line_start,
   input  logic               pixel_credit,
   output logic               pixel_valid,
   output logic               pixel_last,
   output logic [COLOR_W-1:0] pixel_color
);
   logic [VRAM_AW-1:0] dl_base;
   logic [7:0]         charset_base;
   logic [COLOR_W-1:0] border_color;
   logic               pal_wr_en;
   logic [PAL_AW-1:0]  pal_wr_addr;
   logic [COLOR_W-1:0] pal_wr_data;
   logic [VRAM_AW-1:0] dl_addr;
   logic               dl_rd;
   logic [VRAM_AW-1:0] txt_addr;
   logic [15:0]        rd_data;

   vram_wr_if  vram_wr ();
   line_cmd_if cmd ();

   // all port names match the nets above
   cpu_regs      u_cpu_regs (.*);
   vram          u_vram (.*);
   dl_processor  u_dl_processor (.*);
   text_renderer u_text_renderer (.*);

endmodule

// ==== bench/chroni_tb.sv ====
`timescale 1ns/1ps

module chroni_tb
   import chroni_regs_pkg::*;
   import chroni_dl_pkg::*;
();
   localparam int CLK_NS          = 40;
   localparam int TB_LINES        = 25;   // lines rendered over all tests
   localparam int LINE_TIMEOUT    = LINE_PIXELS * 4;
   localparam int WATCHDOG_CYCLES = TB_LINES * LINE_PIXELS * 4 + 10000;

   localparam logic [15:0] DL_WORD  = 16'h0134;   // word origins
   localparam logic [15:0] WIDE_CHR = 16'h0800;
   localparam logic [15:0] WIDE_ATR = 16'h0900;
   localparam logic [15:0] NARW_CHR = 16'h0a00;
   localparam logic [15:0] NARW_ATR = 16'h0b00;
   localparam logic [7:0]  CHARSET  = 8'hbf;      // fonts at byte 0xfc00, crossing into bit 16
   localparam logic [15:0] BORDER   = 16'ha5c3;

   logic               sys_clk = 1'b0;
   logic               reset_n;
   logic [15:0]        cpu_addr;
   logic [7:0]         cpu_wr_data;
   logic               cpu_wr_en;
   logic [7:0]         cpu_rd_data;
   logic               frame_start;
   logic               line_start;
   logic               pixel_credit;
   logic               pixel_valid;
   logic               pixel_last;
   logic [COLOR_W-1:0] pixel_color;

   logic [7:0]              vmem [0:(1<<VRAM_BYTE_AW)-1];   // byte view of VRAM
   logic [COLOR_W-1:0]      pal [0:(1<<PAL_AW)-1];
   logic [VRAM_BYTE_AW-1:0] vaddr_m;
   logic [15:0]             lfsr = 16'd49915;
   logic [COLOR_W-1:0]      exp_q [$];
   logic [COLOR_W-1:0]      rx_q [$];
   int                      last_idx;
   int                      last_count;
   bit                      line_done;
   bit                      hold_credits;
   int                      pending;
   int                      errors;
   int                      checks;
   int                      tests;

   chroni_top dut (
      .sys_clk,
      .reset_n,
      .cpu_addr,
      .cpu_wr_data,
      .cpu_wr_en,
      .cpu_rd_data,
      .frame_start,
      .line_start,
      .pixel_credit,
      .pixel_valid,
      .pixel_last,
      .pixel_color
   );

   always #(CLK_NS / 2) sys_clk = ~sys_clk;

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
      $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
      $display("CHECKS FAILED");
      $finish;
   end

   // pixel sink, sampled mid-cycle
   always @(negedge sys_clk) begin
      if (reset_n && pixel_valid) begin
         rx_q.push_back(pixel_color);
         pending++;
         if (pixel_last) begin
            last_idx = rx_q.size() - 1;
            last_count++;
            line_done = 1'b1;
         end
         if (pending > PIXEL_CREDITS) begin
            $display("ERROR at %0t: %0d pixels outstanding, more than the credits", $time,
                     pending);
            errors++;
         end
      end
   end

   always @(posedge sys_clk) begin
      #5;
      if (!hold_credits && pending > 0) begin   // one credit back per pixel
         pixel_credit = 1'b1;
         pending--;
      end else begin
         pixel_credit = 1'b0;
      end
   end

   task automatic tick();
      @(posedge sys_clk);
      #5;
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, act);
      errors++;
   endtask

   task automatic end_test(input string name, input int e0);
      tests++;
      if (errors == e0)
         $display("test %s: ok", name);
      else
         $display("test %s: %0d errors", name, errors - e0);
   endtask

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [7:0] rand_byte();
      logic [7:0] r;
      r = '0;
      for (int i = 0; i < 8; i++) begin
         lfsr = lfsr_next(lfsr);
         r    = {r[6:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic logic [7:0] font_fill(input int a);
      return 8'((a * 29) ^ (a >> 8) ^ (a >> 16));
   endfunction

   task automatic write_reg(input logic [6:0] off, input logic [7:0] data);
      cpu_addr    = {REG_BASE_HI, off};
      cpu_wr_data = data;
      cpu_wr_en   = 1'b1;
      tick();
      cpu_wr_en = 1'b0;
   endtask

   task automatic read_expect(input logic [6:0] off, input logic [7:0] exp, input string name);
      cpu_addr  = {REG_BASE_HI, off};
      cpu_wr_en = 1'b0;
      tick();   // registered readback
      checks++;
      if (cpu_rd_data !== exp)
         report_mismatch(name, exp, cpu_rd_data);
   endtask

   task automatic set_vaddr(input logic [VRAM_BYTE_AW-1:0] a);
      write_reg(REG_VADDR_LO, a[7:0]);
      write_reg(REG_VADDR_HI, a[15:8]);
      write_reg(REG_VADDR_TOP, {7'd0, a[16]});
      vaddr_m = a;
   endtask

   task automatic vram_put(input logic [7:0] d);
      write_reg(REG_VDATA, d);
      vmem[vaddr_m] = d;
      vaddr_m       = vaddr_m + 1'b1;
   endtask

   task automatic fill_random(input logic [15:0] org, input int n);
      set_vaddr({org, 1'b0});
      repeat (n) vram_put(rand_byte());
   endtask

   task automatic vaddr_expect(input logic [VRAM_BYTE_AW-1:0] a);
      read_expect(REG_VADDR_LO, a[7:0], "vaddr_lo");
      read_expect(REG_VADDR_HI, a[15:8], "vaddr_hi");
      read_expect(REG_VADDR_TOP, {7'd0, a[16]}, "vaddr_top");
   endtask

   task automatic expect_line(input bit blank, input bit narrow, input int chr, input int atr,
                              input int row);
      int         cols;
      logic [7:0] ch;
      logic [7:0] at;
      logic [7:0] fb;
      logic [6:0] page;
      exp_q.delete();
      if (blank) begin
         repeat (LINE_PIXELS) exp_q.push_back(BORDER);
      end else begin
         cols = narrow ? COLS_NARROW : COLS_WIDE;
         for (int c = 0; c < cols; c++) begin
            ch   = vmem[chr * 2 + c];
            at   = vmem[atr * 2 + c];
            page = CHARSET[6:0] + ch[7];   // upper half of the charset sits one page on
            fb   = vmem[{page, ch[6:0], 3'(row)}];
            for (int b = 7; b >= 0; b--)
               exp_q.push_back(fb[b] ? pal[at[3:0]] : pal[at[7:4]]);
         end
      end
   endtask

   task automatic begin_line(input bit blank, input bit narrow, input int chr, input int atr,
                             input int row);
      expect_line(blank, narrow, chr, atr, row);
      rx_q.delete();
      last_idx    = -1;
      last_count  = 0;
      line_done   = 1'b0;
      line_start  = 1'b1;
      tick();
      line_start = 1'b0;
   endtask

   task automatic finish_line(input string what);
      int n;
      n = 0;
      while (!line_done && n < LINE_TIMEOUT) begin
         tick();
         n++;
      end
      if (!line_done) begin
         $display("ERROR at %0t: %s never signalled its last pixel", $time, what);
         errors++;
      end
      tick();
      checks++;
      if (rx_q.size() != exp_q.size())
         report_mismatch({what, " pixel count"}, exp_q.size(), rx_q.size());
      checks++;
      if (last_count != 1 || last_idx != exp_q.size() - 1)
         report_mismatch({what, " pixel_last position"}, exp_q.size(), last_idx + 1);
      for (int i = 0; i < rx_q.size() && i < exp_q.size(); i++) begin
         checks++;
         if (rx_q[i] !== exp_q[i])
            report_mismatch($sformatf("%s pixel_color[%0d]", what, i), exp_q[i], rx_q[i]);
      end
   endtask

   task automatic render_line(input string what, input bit blank, input bit narrow,
                              input int chr, input int atr, input int row);
      begin_line(blank, narrow, chr, atr, row);
      finish_line(what);
   endtask

   task automatic pulse_frame();
      frame_start = 1'b1;
      tick();
      frame_start = 1'b0;
      tick();
   endtask

   task automatic regs_readback();
      int e0;
      e0 = errors;
      write_reg(REG_DL_LO, DL_WORD[7:0]);
      write_reg(REG_DL_HI, DL_WORD[15:8]);
      write_reg(REG_CHARSET, CHARSET);
      set_vaddr(17'h12345);
      write_reg(REG_BORDER_LO, BORDER[7:0]);
      write_reg(REG_BORDER_HI, BORDER[15:8]);
      write_reg(REG_PAL_INDEX, 8'h07);
      read_expect(REG_DL_LO, DL_WORD[7:0], "dl_lo");
      read_expect(REG_DL_HI, DL_WORD[15:8], "dl_hi");
      read_expect(REG_CHARSET, CHARSET, "charset");
      vaddr_expect(17'h12345);
      read_expect(REG_BORDER_LO, BORDER[7:0], "border_lo");
      read_expect(REG_BORDER_HI, BORDER[15:8], "border_hi");
      read_expect(REG_PAL_INDEX, 8'h07, "pal_index");
      end_test("register readback", e0);
   endtask

   task automatic vram_autoinc();
      int          e0;
      logic [15:0] dl_words [8];
      e0 = errors;
      dl_words = '{{4'b0000, DL_MODE_TEXT, 8'd9}, WIDE_CHR, WIDE_ATR,
                   {4'b0001, DL_MODE_TEXT, 8'd9}, NARW_CHR, NARW_ATR,
                   {4'b0000, DL_MODE_BLANK, 8'd2}, {4'b0000, DL_MODE_END, 8'd0}};
      set_vaddr({DL_WORD, 1'b0});
      foreach (dl_words[i]) begin   // little endian, low byte first
         vram_put(dl_words[i][7:0]);
         vram_put(dl_words[i][15:8]);
      end
      vaddr_expect({DL_WORD, 1'b0} + 17'd16);
      fill_random(WIDE_CHR, 2 * COLS_WIDE);   // two text rows each
      fill_random(WIDE_ATR, 2 * COLS_WIDE);
      fill_random(NARW_CHR, 2 * COLS_NARROW);
      fill_random(NARW_ATR, 2 * COLS_NARROW);
      vaddr_expect({NARW_ATR, 1'b0} + 17'(2 * COLS_NARROW));
      set_vaddr({CHARSET[6:0], 10'd0});
      for (int i = 0; i < 256 * CHAR_ROWS; i++)
         vram_put(font_fill(vaddr_m));
      vaddr_expect({CHARSET[6:0], 10'd0} + 17'(256 * CHAR_ROWS));
      end_test("vram auto-increment", e0);
   endtask

   task automatic palette_load();
      int         e0;
      logic [7:0] lo;
      logic [7:0] hi;
      e0 = errors;
      write_reg(REG_PAL_INDEX, 8'd0);
      for (int i = 0; i < (1 << PAL_AW); i++) begin
         lo = rand_byte();
         hi = rand_byte();
         write_reg(REG_PAL_DATA, lo);
         write_reg(REG_PAL_DATA, hi);
         pal[i] = {hi, lo};
      end
      read_expect(REG_PAL_INDEX, 8'd0, "pal_index after wrap");
      end_test("palette auto-increment", e0);
   endtask

   task automatic text_lines();
      int e0;
      e0 = errors;
      pulse_frame();
      for (int i = 0; i < 9; i++)
         render_line($sformatf("wide line %0d", i), 1'b0, 1'b0,
                     WIDE_CHR + (i / CHAR_ROWS) * (COLS_WIDE / 2),
                     WIDE_ATR + (i / CHAR_ROWS) * (COLS_WIDE / 2), i % CHAR_ROWS);
      for (int i = 0; i < 9; i++)
         render_line($sformatf("narrow line %0d", i), 1'b0, 1'b1,
                     NARW_CHR + (i / CHAR_ROWS) * (COLS_NARROW / 2),
                     NARW_ATR + (i / CHAR_ROWS) * (COLS_NARROW / 2), i % CHAR_ROWS);
      end_test("text lines", e0);
   endtask

   task automatic blank_and_end();
      int e0;
      e0 = errors;
      render_line("blank line 0", 1'b1, 1'b0, 0, 0, 0);
      render_line("blank line 1", 1'b1, 1'b0, 0, 0, 0);
      render_line("end marker line", 1'b1, 1'b0, 0, 0, 0);
      render_line("after end line 0", 1'b1, 1'b0, 0, 0, 0);
      render_line("after end line 1", 1'b1, 1'b0, 0, 0, 0);
      pulse_frame();
      render_line("restarted wide line 0", 1'b0, 1'b0, WIDE_CHR, WIDE_ATR, 0);
      end_test("blank and end lines", e0);
   endtask

   task automatic back_pressure();
      int e0;
      e0 = errors;
      hold_credits = 1'b1;
      begin_line(1'b0, 1'b0, WIDE_CHR, WIDE_ATR, 1);
      repeat (60) tick();
      checks++;
      if (rx_q.size() != PIXEL_CREDITS)
         report_mismatch("pixels sent without credits", PIXEL_CREDITS, rx_q.size());
      hold_credits = 1'b0;
      finish_line("stalled wide line 1");
      end_test("back-pressure", e0);
   endtask

   initial begin
      reset_n      = 1'b0;
      cpu_addr     = '0;
      cpu_wr_data  = '0;
      cpu_wr_en    = 1'b0;
      frame_start  = 1'b0;
      line_start   = 1'b0;
      pixel_credit = 1'b0;
      hold_credits = 1'b0;
      vaddr_m      = '0;
      repeat (10) tick();
      reset_n = 1'b1;
      tick();
      regs_readback();
      vram_autoinc();
      palette_load();
      text_lines();
      blank_and_end();
      back_pressure();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

// ==== sim.f ====
hw/chroni_regs_pkg.sv
hw/chroni_dl_pkg.sv
hw/chroni_ifs.sv
hw/cpu_regs.sv
hw/vram.sv
hw/dl_processor.sv
hw/text_renderer.sv
hw/chroni_top.sv
bench/chroni_tb.sv
